/* src/cpuPkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared widths, typedefs and opcodes of the core
////////////////////////////////////////////////////////////////////////////
package cpuPkg;

	// datapath and instruction widths
	localparam int WORD_W = 16;
	localparam int INST_W = 18;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS = 16;
	localparam int FLAG_W = 5;
	// immediate field sits in the low byte of the instruction
	localparam int IMM_W = 8;

	// default data memory depth in address bits
	localparam int MEM_ADDR_W = 8;

	// bit positions inside the flag vector
	localparam int FLAG_CARRY = 4;
	localparam int FLAG_LOW = 3;
	localparam int FLAG_OVF = 2;
	localparam int FLAG_ZERO = 1;
	localparam int FLAG_NEG = 0;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [INST_W-1:0] inst_t;
	typedef logic [REG_ADDR_W-1:0] regAddr_t;
	typedef logic [FLAG_W-1:0] flags_t;

	// codes are contiguous, anything above STOR decodes as NOP
	typedef enum logic [5:0] {
		NOP = 6'd0,
		ADD = 6'd1,
		ADDC = 6'd2,
		SUB = 6'd3,
		CMP = 6'd4,
		AND = 6'd5,
		OR = 6'd6,
		XOR = 6'd7,
		MOV = 6'd8,
		LSH = 6'd9,
		RSH = 6'd10,
		ADDI = 6'd11,
		SUBI = 6'd12,
		MOVI = 6'd13,
		LOAD = 6'd14,
		STOR = 6'd15
	} opcode_e;

endpackage

`default_nettype wire

/* src/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder import cpuPkg::*; (
	input wire CLK,
	input wire rst,
	input wire instValid,
	input wire inst_t instData,
	input wire decReady,
	output logic instReady,
	output logic decValid,
	output opcode_e decOp,
	output regAddr_t decRd,
	output regAddr_t decRs,
	output word_t decImm
);

	// holding register state
	logic holdValid;
	logic take;

	// raw opcode field and its legal mapping
	logic [5:0] rawOp;
	opcode_e mappedOp;

	////////////////////////////////////////////////////////////////////////////
	// handshake
	////////////////////////////////////////////////////////////////////////////

	// free when empty or when execute drains us this cycle
	assign instReady = !holdValid || decReady;
	assign take = instValid && instReady;
	assign decValid = holdValid;

	always_ff @(posedge CLK) begin
		if (rst) begin
			holdValid <= 1'b0;
		end else if (take) begin
			holdValid <= 1'b1;
		end else if (decReady) begin
			// execute consumed the held instruction
			holdValid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// field split
	////////////////////////////////////////////////////////////////////////////

	// opcode lives in bits 17..12
	assign rawOp = instData[17:12];

	always_comb begin
		// unused codes behave as NOP
		if (rawOp > STOR) begin
			mappedOp = NOP;
		end else begin
			mappedOp = opcode_e'(rawOp);
		end
	end

	// payload fields only load on a transfer
	always_ff @(posedge CLK) begin
		if (take) begin
			decOp <= mappedOp;
			// rd in bits 11..8
			decRd <= instData[11:8];
			// rs is the low nibble of the operand byte
			decRs <= instData[3:0];
			// immediate is zero extended
			decImm <= word_t'(instData[IMM_W-1:0]);
		end
	end

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
	input wire CLK,
	input wire rst,
	input wire wrEn,
	input wire regAddr_t wrAddr,
	input wire word_t wrData,
	input wire regAddr_t rdAddrA,
	input wire regAddr_t rdAddrB,
	output word_t rdDataA,
	output word_t rdDataB
);

	// the general registers
	word_t regs [NUM_REGS];

	// one-hot write select
	logic [NUM_REGS-1:0] wrSel;

	// decode the write address into per-register enables
	assign wrSel = wrEn ? (NUM_REGS'(1) << wrAddr) : '0;

	always_ff @(posedge CLK) begin
		for (int i = 0; i < NUM_REGS; i++) begin
			if (rst) begin
				regs[i] <= '0;
			end else if (wrSel[i]) begin
				regs[i] <= wrData;
			end
		end
	end

	// reads are combinational
	// a write shows up for the instruction after the edge
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
	input wire opcode_e op,
	input wire word_t a,
	input wire word_t b,
	input wire carryIn,
	output word_t result,
	output flags_t flagsOut
);

	// result with the carry or borrow in bit 16
	logic [WORD_W:0] wide;

	// operation class for flag forming
	logic isAdd;
	logic isSub;

	////////////////////////////////////////////////////////////////////////////
	// operation select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		isAdd = 1'b0;
		isSub = 1'b0;
		case (op)
			ADD, ADDI: begin
				isAdd = 1'b1;
				wide = {1'b0, a} + {1'b0, b};
			end
			ADDC: begin
				// chains the stored carry
				isAdd = 1'b1;
				wide = {1'b0, a} + {1'b0, b} + {{WORD_W{1'b0}}, carryIn};
			end
			SUB, SUBI, CMP: begin
				// bit 16 goes high on a borrow
				isSub = 1'b1;
				wide = {1'b0, a} - {1'b0, b};
			end
			AND: wide = {1'b0, a & b};
			OR: wide = {1'b0, a | b};
			XOR: wide = {1'b0, a ^ b};
			MOV, MOVI: wide = {1'b0, b};
			// logical shifts by the low nibble of b
			LSH: wide = {1'b0, a << b[3:0]};
			RSH: wide = {1'b0, a >> b[3:0]};
			default: wide = {1'b0, a};
		endcase
	end

	assign result = wide[WORD_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// flags
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// carry only means something for add and subtract
		flagsOut[FLAG_CARRY] = (isAdd || isSub) && wide[WORD_W];
		// unsigned compare of the operands
		flagsOut[FLAG_LOW] = a < b;
		// signed overflow
		if (isAdd) begin
			flagsOut[FLAG_OVF] = (a[WORD_W-1] == b[WORD_W-1]) &&
				(result[WORD_W-1] != a[WORD_W-1]);
		end else if (isSub) begin
			flagsOut[FLAG_OVF] = (a[WORD_W-1] != b[WORD_W-1]) &&
				(result[WORD_W-1] != a[WORD_W-1]);
		end else begin
			flagsOut[FLAG_OVF] = 1'b0;
		end
		flagsOut[FLAG_ZERO] = result == '0;
		flagsOut[FLAG_NEG] = result[WORD_W-1];
	end

endmodule

`default_nettype wire

/* src/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import cpuPkg::*; #(
	parameter int memAddrW = MEM_ADDR_W
) (
	input wire CLK,
	input wire we,
	input wire re,
	input wire [memAddrW-1:0] addr,
	input wire word_t wrData,
	output word_t rdData
);

	// word array, contents survive reset
	word_t mem [2**memAddrW];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wrData;
		end
		// read data is registered, one cycle latency
		if (re) begin
			rdData <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import cpuPkg::*; #(
	parameter int memAddrW = MEM_ADDR_W
) (
	input wire CLK,
	input wire rst,
	input wire decValid,
	input wire opcode_e decOp,
	input wire regAddr_t decRd,
	input wire regAddr_t decRs,
	input wire word_t decImm,
	input wire word_t rdDataA,
	input wire word_t rdDataB,
	input wire word_t aluResult,
	input wire flags_t aluFlags,
	input wire word_t memRdData,
	output logic decReady,
	output regAddr_t rdAddrA,
	output regAddr_t rdAddrB,
	output opcode_e aluOp,
	output word_t aluA,
	output word_t aluB,
	output logic carryIn,
	output logic wrEn,
	output regAddr_t wrAddr,
	output word_t wrData,
	output logic memWe,
	output logic memRe,
	output logic [memAddrW-1:0] memAddr,
	output word_t memWrData,
	output logic wbValid,
	output regAddr_t wbReg,
	output word_t wbData,
	output flags_t storedFlags
);

	typedef enum logic {
		RUN,
		LOADWAIT
	} exState_e;

	exState_e state;
	// destination of the load in flight
	regAddr_t loadRd;
	logic fire;

	// opcode classes
	logic useImm;
	logic writesReg;
	logic setsFlags;

	always_comb begin
		useImm = decOp inside {ADDI, SUBI, MOVI};
		writesReg = decOp inside {ADD, ADDC, SUB, AND, OR, XOR, MOV, LSH, RSH,
			ADDI, SUBI, MOVI};
		setsFlags = decOp inside {ADD, ADDC, SUB, ADDI, SUBI, CMP};
	end

	////////////////////////////////////////////////////////////////////////////
	// operands and memory
	////////////////////////////////////////////////////////////////////////////

	// stalled for one cycle while load data comes back
	assign decReady = state == RUN;
	assign fire = decValid && decReady;

	// rd feeds the A side, rs feeds B and the address
	assign rdAddrA = decRd;
	assign rdAddrB = decRs;
	assign aluOp = decOp;
	assign aluA = rdDataA;
	assign aluB = useImm ? decImm : rdDataB;
	assign carryIn = storedFlags[FLAG_CARRY];

	assign memAddr = rdDataB[memAddrW-1:0];
	assign memWrData = rdDataA;
	assign memWe = fire && (decOp == STOR);
	assign memRe = fire && (decOp == LOAD);

	// register write, memory data wins during the wait state
	always_comb begin
		if (state == LOADWAIT) begin
			wrEn = 1'b1;
			wrAddr = loadRd;
			wrData = memRdData;
		end else begin
			wrEn = fire && writesReg;
			wrAddr = decRd;
			wrData = aluResult;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// state, flags and writeback report
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= RUN;
			storedFlags <= '0;
			wbValid <= 1'b0;
		end else begin
			if (state == LOADWAIT) begin
				state <= RUN;
			end else if (memRe) begin
				state <= LOADWAIT;
			end
			if (fire && setsFlags) begin
				storedFlags <= aluFlags;
			end
			wbValid <= wrEn;
		end
	end

	// payload of the report and pending load target
	always_ff @(posedge CLK) begin
		if (memRe) begin
			loadRd <= decRd;
		end
		wbReg <= wrAddr;
		wbData <= wrData;
	end

endmodule

`default_nettype wire

/* src/cpuCore.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; #(
	parameter int memAddrW = MEM_ADDR_W
) (
	input wire CLK,
	input wire rst,
	input wire instValid,
	input wire inst_t instData,
	output logic instReady,
	output logic wbValid,
	output regAddr_t wbReg,
	output word_t wbData,
	output flags_t storedFlags
);

	////////////////////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////////////////////

	// decode to execute
	logic decValid;
	logic decReady;
	opcode_e decOp;
	regAddr_t decRd;
	regAddr_t decRs;
	word_t decImm;

	// register file ports
	regAddr_t rdAddrA;
	regAddr_t rdAddrB;
	word_t rdDataA;
	word_t rdDataB;
	logic wrEn;
	regAddr_t wrAddr;
	word_t wrData;

	// alu ports
	opcode_e aluOp;
	word_t aluA;
	word_t aluB;
	logic carryIn;
	word_t aluResult;
	flags_t aluFlags;

	// data memory ports
	logic memWe;
	logic memRe;
	logic [memAddrW-1:0] memAddr;
	word_t memWrData;
	word_t memRdData;

	instDecoder decode_i (
		.CLK(CLK),
		.rst(rst),
		.instValid(instValid),
		.instData(instData),
		.decReady(decReady),
		.instReady(instReady),
		.decValid(decValid),
		.decOp(decOp),
		.decRd(decRd),
		.decRs(decRs),
		.decImm(decImm)
	);

	executeStage #(
		.memAddrW(memAddrW)
	) execute_i (
		.CLK(CLK),
		.rst(rst),
		.decValid(decValid),
		.decOp(decOp),
		.decRd(decRd),
		.decRs(decRs),
		.decImm(decImm),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.memRdData(memRdData),
		.decReady(decReady),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.aluOp(aluOp),
		.aluA(aluA),
		.aluB(aluB),
		.carryIn(carryIn),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.memWe(memWe),
		.memRe(memRe),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.storedFlags(storedFlags)
	);

	regFile regs_i (
		.CLK(CLK),
		.rst(rst),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	alu alu_i (
		.op(aluOp),
		.a(aluA),
		.b(aluB),
		.carryIn(carryIn),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	dataMem #(
		.memAddrW(memAddrW)
	) mem_i (
		.CLK(CLK),
		.we(memWe),
		.re(memRe),
		.addr(memAddr),
		.wrData(memWrData),
		.rdData(memRdData)
	);

endmodule

`default_nettype wire

/* tests/cpuCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore_tb import cpuPkg::*; ();

	localparam int CLK_HALF = 5;
	// smaller memory than the default, exercises the parameter path
	localparam int TB_MEM_AW = 6;
	localparam int NUM_RANDOM = 400;
	// upper bound on the directed part of the program
	localparam int NUM_DIRECTED = 120;
	localparam int WATCHDOG_CYCLES = 20 * (NUM_DIRECTED + NUM_RANDOM) * 3;

	logic CLK;
	logic rst;
	logic instValid;
	inst_t instData;
	logic instReady;
	logic wbValid;
	regAddr_t wbReg;
	word_t wbData;
	flags_t storedFlags;

	// reference machine state
	word_t modelRegs [NUM_REGS];
	word_t modelMem [2**TB_MEM_AW];
	bit memWritten [2**TB_MEM_AW];
	flags_t modelFlags;

	// expected register writes, program order
	regAddr_t expRegQ [$];
	word_t expDataQ [$];
	flags_t expFlagsQ [$];

	integer seed = 32'h0cfdf027;
	int valueErrors = 0;
	int otherErrors = 0;
	int writesChecked = 0;
	int stallCycles = 0;

	cpuCore #(
		.memAddrW(TB_MEM_AW)
	) dut_i (
		.CLK(CLK),
		.rst(rst),
		.instValid(instValid),
		.instData(instData),
		.instReady(instReady),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.storedFlags(storedFlags)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_HALF) CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic inst_t regInst(input opcode_e op, input regAddr_t rd,
		input regAddr_t rs);
		return {op, rd, 4'b0000, rs};
	endfunction

	function automatic inst_t immInst(input opcode_e op, input regAddr_t rd,
		input logic [7:0] val);
		return {op, rd, val};
	endfunction

	// one instruction applied to the model, gives back the expected write
	function automatic void applyModel(input inst_t inst, output logic writes,
		output regAddr_t dest, output word_t value);
		logic [5:0] op;
		regAddr_t rs;
		word_t a;
		word_t b;
		word_t r;
		logic cin;
		logic arith;
		int ures;
		int sres;
		logic [TB_MEM_AW-1:0] addr;
		op = inst[17:12];
		dest = inst[11:8];
		rs = inst[3:0];
		a = modelRegs[dest];
		// immediate is the zero extended low byte
		b = (op == ADDI || op == SUBI || op == MOVI) ? word_t'(inst[7:0]) : modelRegs[rs];
		addr = modelRegs[rs][TB_MEM_AW-1:0];
		cin = (op == ADDC) ? modelFlags[FLAG_CARRY] : 1'b0;
		writes = 1'b1;
		arith = 1'b0;
		ures = 0;
		sres = 0;
		r = '0;
		case (op)
			ADD, ADDC, ADDI: begin
				ures = int'(a) + int'(b) + int'(cin);
				sres = int'($signed(a)) + int'($signed(b)) + int'(cin);
				arith = 1'b1;
			end
			SUB, SUBI, CMP: begin
				ures = int'(a) - int'(b);
				sres = int'($signed(a)) - int'($signed(b));
				arith = 1'b1;
				writes = op != CMP;
			end
			AND: r = a & b;
			OR: r = a | b;
			XOR: r = a ^ b;
			MOV, MOVI: r = b;
			LSH: r = a << b[3:0];
			RSH: r = a >> b[3:0];
			LOAD: r = modelMem[addr];
			STOR: begin
				modelMem[addr] = a;
				memWritten[addr] = 1'b1;
				writes = 1'b0;
			end
			// NOP and every unused code
			default: writes = 1'b0;
		endcase
		if (arith) begin
			r = word_t'(ures);
			// out of range above is a carry, below zero a borrow
			modelFlags[FLAG_CARRY] = (ures > 65535) || (ures < 0);
			modelFlags[FLAG_LOW] = a < b;
			modelFlags[FLAG_OVF] = (sres > 32767) || (sres < -32768);
			modelFlags[FLAG_ZERO] = r == '0;
			modelFlags[FLAG_NEG] = r[WORD_W-1];
		end
		if (writes) begin
			modelRegs[dest] = r;
		end
		value = r;
	endfunction

	// random instruction, loads only from words already stored
	function automatic inst_t randomInst();
		logic [5:0] op;
		regAddr_t rd;
		logic [7:0] low;
		logic [TB_MEM_AW-1:0] addr;
		op = 6'($unsigned($random(seed)) % 16);
		// now and then a raw code, most of them unused
		if (($random(seed) & 15) == 0) begin
			op = 6'($random(seed));
		end
		rd = regAddr_t'($random(seed));
		low = 8'($random(seed));
		addr = modelRegs[low[3:0]][TB_MEM_AW-1:0];
		if (op == LOAD && !memWritten[addr]) begin
			op = STOR;
		end
		return {op, rd, low};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// driving and checking
	////////////////////////////////////////////////////////////////////////////

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic sendInst(input inst_t inst);
		logic writes;
		regAddr_t dest;
		word_t value;
		instValid = 1'b1;
		instData = inst;
		// instReady is stable here, low means back-pressure
		while (instReady !== 1'b1) begin
			stallCycles++;
			@(negedge CLK);
		end
		applyModel(inst, writes, dest, value);
		if (writes) begin
			expRegQ.push_back(dest);
			expDataQ.push_back(value);
			expFlagsQ.push_back(modelFlags);
		end
		@(negedge CLK);
		instValid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic waitIdle();
		while (expRegQ.size() != 0) begin
			@(negedge CLK);
		end
		// room for a trailing CMP or STOR to retire
		repeat (4) @(negedge CLK);
	endtask

	task automatic checkFlagsNow();
		if (storedFlags !== modelFlags) begin
			$display("FAILED at %0t: storedFlags got %b expected %b", $time, storedFlags,
				modelFlags);
			valueErrors++;
		end
	endtask

	// one queue entry per wbValid cycle
	always @(negedge CLK) begin : compareWrites
		regAddr_t eReg;
		word_t eData;
		flags_t eFlags;
		if (!rst && wbValid === 1'b1) begin
			if (expRegQ.size() == 0) begin
				$display("ERROR at %0t: write to r%0d reported with no write pending", $time,
					wbReg);
				otherErrors++;
			end else begin
				eReg = expRegQ.pop_front();
				eData = expDataQ.pop_front();
				eFlags = expFlagsQ.pop_front();
				writesChecked++;
				if (wbReg !== eReg) begin
					$display("FAILED at %0t: wbReg got %0d expected %0d", $time, wbReg, eReg);
					valueErrors++;
				end
				if (wbData !== eData) begin
					$display("FAILED at %0t: wbData got %h expected %h", $time, wbData, eData);
					valueErrors++;
				end
				// flags already hold this instruction's effect
				if (storedFlags !== eFlags) begin
					$display("FAILED at %0t: storedFlags got %b expected %b", $time,
						storedFlags, eFlags);
					valueErrors++;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("ERROR: no end after %0d cycles, %0d value errors, %0d other errors",
			WATCHDOG_CYCLES, valueErrors, otherErrors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// program
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int stallsBefore;
		rst = 1'b1;
		instValid = 1'b0;
		instData = '0;
		modelFlags = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			modelRegs[i] = '0;
		end
		repeat (10) @(negedge CLK);
		rst = 1'b0;

		// reset state
		if (wbValid !== 1'b0) begin
			$display("FAILED at %0t: wbValid got %b expected 0", $time, wbValid);
			valueErrors++;
		end
		if (instReady !== 1'b1) begin
			$display("FAILED at %0t: instReady got %b expected 1", $time, instReady);
			valueErrors++;
		end
		checkFlagsNow();

		// fill every register, then a dependent MOV chain
		for (int i = 0; i < NUM_REGS; i++) begin
			sendInst(immInst(MOVI, regAddr_t'(i), 8'(i * 37 + 11)));
		end
		for (int i = 1; i < NUM_REGS; i++) begin
			sendInst(regInst(MOV, regAddr_t'(i), regAddr_t'(i - 1)));
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			sendInst(immInst(MOVI, regAddr_t'(i), 8'(i * 53 + 7)));
		end

		// arithmetic around the signed limits and carry chaining
		sendInst(immInst(MOVI, 4, 8));
		sendInst(immInst(MOVI, 3, 8'h80));
		sendInst(regInst(LSH, 3, 4));
		sendInst(immInst(MOVI, 5, 8'h7f));
		sendInst(regInst(LSH, 5, 4));
		sendInst(immInst(ADDI, 5, 8'hff));
		// 7fff + 1 and back
		sendInst(immInst(ADDI, 5, 8'h01));
		sendInst(immInst(SUBI, 5, 8'h01));
		sendInst(regInst(ADD, 3, 3));
		sendInst(immInst(MOVI, 6, 8'h00));
		sendInst(immInst(SUBI, 6, 8'h01));
		sendInst(immInst(ADDI, 6, 8'h01));
		sendInst(regInst(ADDC, 7, 8));
		sendInst(regInst(ADDC, 7, 8));
		sendInst(regInst(SUB, 9, 10));
		sendInst(regInst(SUB, 10, 9));
		for (int n = 0; n < 8; n++) begin
			sendInst(regInst(opcode_e'(6'(1 + $unsigned($random(seed)) % 3)),
				regAddr_t'($random(seed)), regAddr_t'($random(seed))));
		end

		// compare sets flags only, logic ops keep them
		sendInst(regInst(CMP, 1, 2));
		waitIdle();
		checkFlagsNow();
		sendInst(regInst(CMP, 2, 1));
		waitIdle();
		checkFlagsNow();
		sendInst(regInst(CMP, 4, 4));
		waitIdle();
		checkFlagsNow();
		sendInst(regInst(AND, 1, 2));
		sendInst(regInst(OR, 2, 3));
		sendInst(regInst(XOR, 3, 4));
		sendInst(regInst(LSH, 9, 4));
		sendInst(regInst(RSH, 10, 4));
		waitIdle();
		checkFlagsNow();

		// stores and loads, loads stall the handshake
		stallsBefore = stallCycles;
		sendInst(immInst(MOVI, 10, 8'h10));
		sendInst(immInst(MOVI, 11, 8'h23));
		sendInst(regInst(STOR, 1, 10));
		sendInst(regInst(STOR, 2, 11));
		sendInst(regInst(LOAD, 12, 10));
		sendInst(regInst(LOAD, 13, 11));
		sendInst(regInst(LOAD, 14, 10));
		sendInst(regInst(STOR, 5, 10));
		sendInst(regInst(LOAD, 15, 10));
		waitIdle();
		if (stallCycles == stallsBefore) begin
			$display("ERROR: instReady never dropped while loads were in flight");
			otherErrors++;
		end

		// back to back dependences, also through a load
		sendInst(immInst(MOVI, 1, 8'h05));
		sendInst(regInst(ADD, 2, 1));
		sendInst(immInst(ADDI, 2, 8'h03));
		sendInst(regInst(SUB, 1, 2));
		sendInst(regInst(LOAD, 3, 10));
		sendInst(regInst(ADD, 4, 3));
		sendInst(regInst(STOR, 4, 11));
		sendInst(regInst(LOAD, 6, 11));
		sendInst(regInst(XOR, 6, 4));
		waitIdle();

		// long random program with gaps on instValid
		for (int n = 0; n < NUM_RANDOM; n++) begin
			sendInst(randomInst());
			if (($random(seed) & 3) == 0) begin
				idle(($random(seed) & 3) + 1);
			end
		end
		waitIdle();
		checkFlagsNow();

		$display("checked %0d writes, %0d value errors, %0d other errors", writesChecked,
			valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* cpuCore.f */
src/cpuPkg.sv
src/instDecoder.sv
src/regFile.sv
src/alu.sv
src/dataMem.sv
src/executeStage.sv
src/cpuCore.sv
tests/cpuCore_tb.sv

/* Makefile */
# Verilator flow for the cpuCore project
# any variable below can be overridden on the make command line

VERILATOR ?= verilator
FILE_LIST ?= cpuCore.f
RTL_TOP ?= cpuCore
TB_TOP ?= cpuCore_tb
OBJ_DIR ?= obj_dir
SIM_LOG ?= sim.log
VFLAGS ?= --timing
LINT_FLAGS ?= -Wall
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# the run passes only if the log holds the pass message
sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	grep -q "$(PASS_TEXT)" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
